// ==== Makefile ====
# Lint, simulate and clean with Verilator

TOP = srrc_filter_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module srrc_filter \
		rtl/srrc_pkg.sv rtl/srrc_tap_line.sv rtl/srrc_coef_mult.sv \
		rtl/srrc_sum_out.sv rtl/srrc_filter.sv
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f srrc_filter.f

obj_dir/V$(TOP): srrc_filter.f rtl/*.sv testbench/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f srrc_filter.f

# The run passes only if the log holds the pass line
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== rtl/srrc_coef_mult.sv ====
module srrc_coef_mult #(
	parameter int NUM_TAPS = srrc_pkg::NUM_TAPS_DEFAULT
) (
	input srrc_pkg::fold_t folds [0:NUM_TAPS/2],
	output srrc_pkg::product_t products [0:NUM_TAPS/2]
);

	import srrc_pkg::*;

	localparam int NUM_FOLDS = NUM_TAPS / 2 + 1;
	localparam int CENTER = NUM_FOLDS - 1;

	// Folded sums reachable from two legal symbols
	localparam fold_t F_LO = fold_t'(LEVEL_LO);
	localparam fold_t F_HI = fold_t'(LEVEL_HI);
	localparam fold_t F_LO2 = fold_t'(2 * LEVEL_LO);
	localparam fold_t F_MID = fold_t'(LEVEL_LO + LEVEL_HI);
	localparam fold_t F_HI2 = fold_t'(2 * LEVEL_HI);

	for (genvar g = 0; g < NUM_FOLDS; g++)
	begin : g_pos
		// Products are constants per position, so each tap is a small ROM
		localparam product_t P_LO = product_t'(COEFS[g]) * product_t'(LEVEL_LO);
		localparam product_t P_HI = product_t'(COEFS[g]) * product_t'(LEVEL_HI);

		if (g == CENTER)
		begin : g_center
			// Single tap, so only one symbol can be present
			always_comb
			begin
				case (folds[g])
					F_LO:
						products[g] = P_LO;
					-F_LO:
						products[g] = -P_LO;
					F_HI:
						products[g] = P_HI;
					-F_HI:
						products[g] = -P_HI;
					default:
						products[g] = '0;
				endcase
			end
		end
		else
		begin : g_pair
			localparam product_t P_LO2 = P_LO + P_LO;
			localparam product_t P_MID = P_LO + P_HI;
			localparam product_t P_HI2 = P_HI + P_HI;

			// Zero and any illegal fold fall through to the default
			always_comb
			begin
				case (folds[g])
					F_LO:
						products[g] = P_LO;
					-F_LO:
						products[g] = -P_LO;
					F_HI:
						products[g] = P_HI;
					-F_HI:
						products[g] = -P_HI;
					F_LO2:
						products[g] = P_LO2;
					-F_LO2:
						products[g] = -P_LO2;
					F_MID:
						products[g] = P_MID;
					-F_MID:
						products[g] = -P_MID;
					F_HI2:
						products[g] = P_HI2;
					-F_HI2:
						products[g] = -P_HI2;
					default:
						products[g] = '0;
				endcase
			end
		end
	end

endmodule

// ==== rtl/srrc_filter.sv ====
module srrc_filter #(
	parameter int NUM_TAPS = srrc_pkg::NUM_TAPS_DEFAULT
) (
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input srrc_pkg::sample_t x_in,
	output srrc_pkg::sample_t y
);

	import srrc_pkg::*;

	// One entry per coefficient, center last
	fold_t folds [0:NUM_TAPS/2];
	product_t products [0:NUM_TAPS/2];

	// Delay line and symmetric pre-add
	srrc_tap_line #(
		.NUM_TAPS(NUM_TAPS)
	) u_tap_line (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.x_in(x_in),
		.folds(folds)
	);

	// Level lookup in place of multipliers
	srrc_coef_mult #(
		.NUM_TAPS(NUM_TAPS)
	) u_coef_mult (
		.folds(folds),
		.products(products)
	);

	// Truncate, accumulate and register
	srrc_sum_out #(
		.NUM_TAPS(NUM_TAPS)
	) u_sum_out (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.products(products),
		.y(y)
	);

endmodule

// ==== rtl/srrc_pkg.sv ====
package srrc_pkg;

	// Sample path widths
	// Samples are 1s17, coefficients 0s18
	localparam int SAMPLE_W = 18;
	localparam int COEF_W = 18;

	// One guard bit so that two folded taps never overflow
	localparam int FOLD_W = SAMPLE_W + 1;

	// Full precision product of a fold and a coefficient
	localparam int PRODUCT_W = FOLD_W + COEF_W;

	// Fraction bits dropped to bring a product back to 1s17
	localparam int PRODUCT_SHIFT = 18;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [FOLD_W-1:0] fold_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [PRODUCT_W-1:0] product_t;

	// PAM-4 symbol magnitudes in 1s17
	// 0.25 and 0.75 of full scale
	localparam int LEVEL_LO = 32768;
	localparam int LEVEL_HI = 98304;

	// Tap count of the filter, must be odd
	localparam int NUM_TAPS_DEFAULT = 21;

	// Distinct SRRC coefficients in 0s18
	// Index i weights taps i and NUM_TAPS-1-i, the center tap is last
	localparam coef_t COEFS [0:NUM_TAPS_DEFAULT/2] = '{
		// Taps 0 and 20
		18'sd12693,
		// Taps 1 and 19
		18'sd11699,
		// Taps 2 and 18
		18'sd2289,
		// Taps 3 and 17
		-18'sd11610,
		// Taps 4 and 16
		-18'sd22018,
		// Taps 5 and 15
		-18'sd20455,
		// Taps 6 and 14
		-18'sd2333,
		// Taps 7 and 13
		18'sd30008,
		// Taps 8 and 12
		18'sd67374,
		// Taps 9 and 11
		18'sd97118,
		// Center tap 10
		18'sd108441
	};

endpackage

// ==== rtl/srrc_sum_out.sv ====
module srrc_sum_out #(
	parameter int NUM_TAPS = srrc_pkg::NUM_TAPS_DEFAULT
) (
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input srrc_pkg::product_t products [0:NUM_TAPS/2],
	output srrc_pkg::sample_t y
);

	import srrc_pkg::*;

	localparam int NUM_FOLDS = NUM_TAPS / 2 + 1;

	sample_t trunc [0:NUM_FOLDS-1];
	sample_t partial [0:NUM_FOLDS-1];

	// Floor to 1s17 by dropping the low fraction bits
	for (genvar g = 0; g < NUM_FOLDS; g++)
	begin : g_trunc
		assign trunc[g] = sample_t'(products[g] >>> PRODUCT_SHIFT);
	end

	// Adder chain, wraps at 18 bits like the output format
	assign partial[0] = trunc[0];

	for (genvar g = 1; g < NUM_FOLDS; g++)
	begin : g_chain
		assign partial[g] = partial[g-1] + trunc[g];
	end

	// Output updates once per sample
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			y <= '0;
		else if (sam_clk_en)
			y <= partial[NUM_FOLDS-1];
	end

endmodule

// ==== rtl/srrc_tap_line.sv ====
module srrc_tap_line #(
	parameter int NUM_TAPS = srrc_pkg::NUM_TAPS_DEFAULT
) (
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input srrc_pkg::sample_t x_in,
	output srrc_pkg::fold_t folds [0:NUM_TAPS/2]
);

	import srrc_pkg::*;

	localparam int NUM_FOLDS = NUM_TAPS / 2 + 1;
	localparam int MID = NUM_TAPS / 2;

	sample_t taps [0:NUM_TAPS-1];

	// First tap samples the input on every clock
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			taps[0] <= '0;
		else
			taps[0] <= x_in;
	end

	// Rest of the delay line only moves on the sample strobe
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 1; i < NUM_TAPS; i++)
				taps[i] <= '0;
		end
		else if (sam_clk_en)
		begin
			for (int i = 1; i < NUM_TAPS; i++)
				taps[i] <= taps[i-1];
		end
	end

	// Pre-add the mirrored taps that share a coefficient
	always_comb
	begin
		for (int i = 0; i < NUM_FOLDS - 1; i++)
		begin
			folds[i] = {taps[i][SAMPLE_W-1], taps[i]}
				+ {taps[NUM_TAPS-1-i][SAMPLE_W-1], taps[NUM_TAPS-1-i]};
		end
		// Middle tap has no partner
		folds[NUM_FOLDS-1] = {taps[MID][SAMPLE_W-1], taps[MID]};
	end

endmodule

// ==== srrc_filter.f ====
rtl/srrc_pkg.sv
rtl/srrc_tap_line.sv
rtl/srrc_coef_mult.sv
rtl/srrc_sum_out.sv
rtl/srrc_filter.sv
testbench/srrc_filter_checker.sv
testbench/srrc_filter_tb.sv

// ==== testbench/srrc_filter_checker.sv ====
module srrc_filter_checker (
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input srrc_pkg::sample_t y
);

	timeunit 1ns;
	timeprecision 1ps;

	// Output register clears with the asynchronous reset
	reset_clears_y: assert property (
		@(posedge clk) reset |-> y == '0
	) else $error("y is not zero while reset is high");

	// y may only move at an edge that saw the strobe
	y_holds_without_strobe: assert property (
		@(posedge clk) disable iff (reset)
		!$past(sam_clk_en) |-> $stable(y)
	) else $error("y changed at an edge without sam_clk_en");

endmodule

bind srrc_filter srrc_filter_checker u_checker (
	.clk(clk),
	.reset(reset),
	.sam_clk_en(sam_clk_en),
	.y(y)
);

// ==== testbench/srrc_filter_tb.sv ====
module srrc_filter_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import srrc_pkg::*;

	localparam int NUM_TAPS = NUM_TAPS_DEFAULT;
	localparam int NUM_FOLDS = NUM_TAPS / 2 + 1;
	localparam int RESET_CYCLES = 10;
	localparam int MARGIN_CYCLES = 50;
	localparam int NUM_TESTS = 5;
	localparam int NUM_RANDOM = 120;

	logic clk;
	logic reset;
	logic sam_clk_en;
	sample_t x_in;
	sample_t y;

	// Stimulus table, one row per clock
	sample_t row_x [$];
	logic row_en [$];
	int row_test [$];

	// Reference copy of the delay line and output register
	sample_t model_taps [0:NUM_TAPS-1];
	sample_t model_y;

	// Strobed outputs of an impulse test
	sample_t impulse_y [$];

	integer seed;
	int cycle_count = 0;
	int cycle_limit = 0;
	int current_test;
	int total_checks = 0;
	int total_errors = 0;
	int test_checks = 0;
	int test_errors = 0;

	srrc_filter #(
		.NUM_TAPS(NUM_TAPS)
	) DUT (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.x_in(x_in),
		.y(y)
	);

	initial
		clk = 1'b0;

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	function automatic sample_t level_of(input logic [1:0] code);
		case (code)
			2'd0:
				return sample_t'(-LEVEL_HI);
			2'd1:
				return sample_t'(-LEVEL_LO);
			2'd2:
				return sample_t'(LEVEL_LO);
			default:
				return sample_t'(LEVEL_HI);
		endcase
	endfunction

	function automatic string test_name(input int test);
		case (test)
			1:
				return "reset";
			2:
				return "positive impulse";
			3:
				return "negative impulse";
			4:
				return "hold";
			default:
				return "random pam stream";
		endcase
	endfunction

	// Exact products of the mirrored taps, floored and wrapped to 18 bits
	function automatic sample_t filter_sum();
		longint pair;
		longint term;
		sample_t acc;
		acc = '0;
		for (int i = 0; i < NUM_FOLDS; i++)
		begin
			if (i == NUM_FOLDS - 1)
				pair = longint'(model_taps[i]);
			else
				pair = longint'(model_taps[i]) + longint'(model_taps[NUM_TAPS-1-i]);
			term = (pair * longint'(COEFS[i])) >>> PRODUCT_SHIFT;
			acc = acc + sample_t'(term);
		end
		return acc;
	endfunction

	task automatic model_step(input sample_t x, input logic en);
		if (en)
		begin
			model_y = filter_sum();
			for (int i = NUM_TAPS - 1; i > 0; i--)
				model_taps[i] = model_taps[i-1];
		end
		// First tap follows the input on every edge
		model_taps[0] = x;
	endtask

	task automatic check_value(input sample_t actual, input sample_t expected, input string what);
		total_checks++;
		test_checks++;
		if (actual !== expected)
		begin
			total_errors++;
			test_errors++;
			$display("error at %0d ns: %s, got %0d, expected %0d",
				$time, what, actual, expected);
		end
	endtask

	task automatic add_row(input sample_t x, input logic en, input int test);
		row_x.push_back(x);
		row_en.push_back(en);
		row_test.push_back(test);
	endtask

	task automatic build_table();
		logic [31:0] r;
		int gap;
		sample_t sym;
		for (int i = 0; i < 16; i++)
			add_row('0, 1'b1, 1);
		add_row(sample_t'(LEVEL_LO), 1'b1, 2);
		for (int i = 0; i < NUM_TAPS + 4; i++)
			add_row('0, 1'b1, 2);
		add_row(sample_t'(-LEVEL_HI), 1'b1, 3);
		for (int i = 0; i < NUM_TAPS + 4; i++)
			add_row('0, 1'b1, 3);
		// A few symbols, then x_in moves with the strobe low
		add_row(sample_t'(LEVEL_HI), 1'b1, 4);
		add_row(sample_t'(-LEVEL_LO), 1'b1, 4);
		for (int i = 0; i < 6; i++)
			add_row(level_of(2'(i)), 1'b0, 4);
		add_row(sample_t'(LEVEL_LO), 1'b1, 4);
		for (int i = 0; i < 3; i++)
			add_row(level_of(2'(i + 1)), 1'b0, 4);
		for (int i = 0; i < NUM_TAPS + 2; i++)
			add_row('0, 1'b1, 4);
		// Symbol on the strobe, held through a random gap
		for (int s = 0; s < NUM_RANDOM; s++)
		begin
			r = $random(seed);
			sym = level_of(r[1:0]);
			gap = int'(r[3:2]);
			add_row(sym, 1'b1, 5);
			for (int g = 0; g < gap; g++)
				add_row(sym, 1'b0, 5);
		end
		for (int i = 0; i < NUM_TAPS; i++)
			add_row('0, 1'b1, 5);
	endtask

	// Impulse response in tap order, symmetric about the center tap
	task automatic check_impulse(input longint amplitude);
		int first;
		int idx;
		sample_t expected;
		first = -1;
		for (int k = 0; k < impulse_y.size(); k++)
		begin
			if (first < 0 && impulse_y[k] != '0)
				first = k;
		end
		if (first < 0 || first + NUM_TAPS > impulse_y.size())
		begin
			total_errors++;
			test_errors++;
			$display("impulse test at %0d ns did not give %0d output samples",
				$time, NUM_TAPS);
		end
		else
		begin
			for (int k = 0; k < NUM_TAPS; k++)
			begin
				idx = (k < NUM_FOLDS) ? k : NUM_TAPS - 1 - k;
				expected = sample_t'((longint'(COEFS[idx]) * amplitude) >>> PRODUCT_SHIFT);
				check_value(impulse_y[first + k], expected, $sformatf("impulse tap %0d", k));
			end
			for (int k = 0; k < NUM_FOLDS - 1; k++)
			begin
				check_value(impulse_y[first + k], impulse_y[first + NUM_TAPS - 1 - k],
					$sformatf("impulse symmetry at tap %0d", k));
			end
		end
	endtask

	task automatic finish_test(input int test);
		if (test == 2)
			check_impulse(longint'(LEVEL_LO));
		else if (test == 3)
			check_impulse(-longint'(LEVEL_HI));
		$display("test %0d %s: %0d checks, %0d errors",
			test, test_name(test), test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
		impulse_y.delete();
	endtask

	initial
	begin
		seed = 32'hefafd3af;
		reset = 1'b1;
		sam_clk_en = 1'b0;
		x_in = '0;
		for (int i = 0; i < NUM_TAPS; i++)
			model_taps[i] = '0;
		model_y = '0;
		build_table();
		cycle_limit = row_x.size() + RESET_CYCLES + MARGIN_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		current_test = row_test[0];
		check_value(y, '0, "y after reset");

		for (int r = 0; r < row_x.size(); r++)
		begin
			if (row_test[r] != current_test)
			begin
				finish_test(current_test);
				current_test = row_test[r];
			end
			x_in = row_x[r];
			sam_clk_en = row_en[r];
			@(posedge clk);
			#1;
			model_step(row_x[r], row_en[r]);
			check_value(y, model_y, $sformatf("y at row %0d", r));
			if ((current_test == 2 || current_test == 3) && row_en[r])
				impulse_y.push_back(y);
		end
		finish_test(current_test);

		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, total_checks, total_errors);
		if (total_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
